// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = dcache_tb
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/dcache_properties.sv ====
/*
 * Port-level invariants of the data cache, bound into dcache_top
 */
`default_nettype none

module dcache_properties
	import dcache_pkg::*;
(
	input wire logic                    clock,
	input wire logic                    reset,
	input wire logic                    proc_valid,
	input wire logic [mem_tag_bits-1:0] proc_tag,
	input wire logic [mem_tag_bits-1:0] mem_tag,
	input wire bus_command_e            mem_command,
	input wire logic [addr_bits-1:0]    mem_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	// Tagged data only comes back with a fill
	tagged_data_in_fill: assert property (@(posedge clock) disable iff (reset)
		(proc_valid && (proc_tag != '0)) |-> (mem_tag != '0))
		else $error("tagged processor response outside a fill cycle");

	// Fills block the memory request side
	no_request_in_fill: assert property (@(posedge clock) disable iff (reset)
		(mem_tag != '0) |-> (mem_command == bus_none))
		else $error("memory command issued during a fill");

	word_aligned_addr: assert property (@(posedge clock) disable iff (reset)
		(mem_command != bus_none) |-> (mem_addr[offset_bits-1:0] == '0))
		else $error("memory address not word aligned");

endmodule

bind dcache_top dcache_properties u_properties (.*);

`default_nettype wire

// ==== dv/dcache_tb.sv ====
/*
 * Directed testbench for the data cache
 * Plays the tagged memory and checks every cycle against a reference model
 */
`default_nettype none

module dcache_tb
	import dcache_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int timeout_cycles = 1000;

	logic                    clock;
	logic                    reset;
	bus_command_e            proc_command;
	logic [addr_bits-1:0]    proc_addr;
	logic [data_bits-1:0]    proc_data;
	logic [data_bits-1:0]    proc_rd_data;
	logic                    proc_valid;
	logic [mem_tag_bits-1:0] proc_tag;
	logic [mem_tag_bits-1:0] mem_response;
	logic [mem_tag_bits-1:0] mem_tag;
	logic [data_bits-1:0]    mem_rd_data;
	bus_command_e            mem_command;
	logic [addr_bits-1:0]    mem_addr;
	logic [data_bits-1:0]    mem_wr_data;

	// Outputs captured mid-cycle
	logic [data_bits-1:0]    got_rd_data;
	logic                    got_valid;
	logic [mem_tag_bits-1:0] got_tag;
	bus_command_e            got_cmd;
	logic [addr_bits-1:0]    got_addr;
	logic [data_bits-1:0]    got_wr_data;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	logic [data_bits-1:0]       mem_words [logic [addr_bits-1:0]];  // Sparse memory
	logic                       model_valid [dcache_lines];
	logic [dcache_tag_bits-1:0] model_tag   [dcache_lines];
	logic [data_bits-1:0]       model_data  [dcache_lines];
	logic                       miss_pending [mt_entries];
	logic [addr_bits-1:0]       miss_addr_q  [mt_entries];
	logic [mem_tag_bits-1:0]    next_tag;  // Memory tag counter from 1 to 15
	int                         cycle_count = 0;

	dcache_top u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("Simulation failed");
			$fatal(1, "stopped by timeout");
		end
	end

	function automatic logic [addr_bits-1:0] word_addr(input logic [addr_bits-1:0] a);
		return {a[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
	endfunction

	function automatic logic [dcache_idx_bits-1:0] line_idx(input logic [addr_bits-1:0] a);
		return a[offset_bits +: dcache_idx_bits];
	endfunction

	function automatic logic [dcache_tag_bits-1:0] line_tag(input logic [addr_bits-1:0] a);
		return a[offset_bits + dcache_idx_bits +: dcache_tag_bits];
	endfunction

	task automatic clear_model();
		for (int i = 0; i < dcache_lines; i++)
			model_valid[i] = 1'b0;
		for (int i = 0; i < mt_entries; i++)
			miss_pending[i] = 1'b0;
		next_tag = 4'd1;
	endtask

	task automatic drive_idle();
		proc_command = bus_none;
		proc_addr    = '0;
		proc_data    = '0;
		mem_response = '0;
		mem_tag      = '0;
		mem_rd_data  = '0;
	endtask

	// Second reset in mid-run also restarts the memory tag counter
	task automatic reset_dut();
		@(negedge clock);
		reset = 1'b1;
		drive_idle();
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		clear_model();
	endtask

	task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	// One clock cycle of stimulus; outputs sampled 1 ns after the drive
	task automatic step(input bus_command_e cmd, input logic [addr_bits-1:0] addr,
			input logic [data_bits-1:0] data, input logic [mem_tag_bits-1:0] resp,
			input logic [mem_tag_bits-1:0] tag, input logic [data_bits-1:0] rdata);
		@(negedge clock);
		proc_command = cmd;
		proc_addr    = addr;
		proc_data    = data;
		mem_response = resp;
		mem_tag      = tag;
		mem_rd_data  = rdata;
		#1;
		got_rd_data = proc_rd_data;
		got_valid   = proc_valid;
		got_tag     = proc_tag;
		got_cmd     = mem_command;
		got_addr    = mem_addr;
		got_wr_data = mem_wr_data;
		@(posedge clock);
	endtask

	task automatic check_outputs(input logic valid, input logic [mem_tag_bits-1:0] tag,
			input logic [data_bits-1:0] rd, input bus_command_e cmd,
			input logic [addr_bits-1:0] addr, input logic [data_bits-1:0] wr);
		expect_eq("proc_valid", 64'(got_valid), 64'(valid));
		expect_eq("proc_tag", 64'(got_tag), 64'(tag));
		if (valid)
			expect_eq("proc_rd_data", got_rd_data, rd);
		expect_eq("mem_command", 64'(got_cmd), 64'(cmd));
		if (cmd != bus_none)
			expect_eq("mem_addr", got_addr, addr);
		if (cmd == bus_store)
			expect_eq("mem_wr_data", got_wr_data, wr);
	endtask

	task automatic store_word(input logic [addr_bits-1:0] addr, input logic [data_bits-1:0] data);
		logic [dcache_idx_bits-1:0] idx;
		idx = line_idx(addr);
		step(bus_store, addr, data, '0, '0, '0);
		check_outputs(1'b0, '0, '0, bus_store, word_addr(addr), data);
		model_valid[idx] = 1'b1;  // Write-through fills the line too
		model_tag[idx]   = line_tag(addr);
		model_data[idx]  = data;
		mem_words[word_addr(addr)] = data;
	endtask

	task automatic load_word(input logic [addr_bits-1:0] addr, input bit refuse,
			output logic [mem_tag_bits-1:0] tag_out);
		logic [dcache_idx_bits-1:0] idx;
		logic                       hit;
		logic [mem_tag_bits-1:0]    resp;
		idx  = line_idx(addr);
		hit  = model_valid[idx] && (model_tag[idx] == line_tag(addr));
		resp = refuse ? 4'd0 : next_tag;
		tag_out = '0;
		step(bus_load, addr, '0, resp, '0, '0);
		if (hit) begin
			check_outputs(1'b1, '0, model_data[idx], bus_none, '0, '0);
		end else if (resp != '0) begin
			check_outputs(1'b0, resp, '0, bus_load, word_addr(addr), '0);
			miss_pending[resp] = 1'b1;
			miss_addr_q[resp]  = word_addr(addr);
			tag_out  = resp;
			next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
		end else begin
			check_outputs(1'b0, '0, '0, bus_none, '0, '0);  // Refused so the processor retries
		end
	endtask

	task automatic return_fill(input logic [mem_tag_bits-1:0] tag);
		logic [data_bits-1:0]       data;
		logic [addr_bits-1:0]       wa;
		logic [dcache_idx_bits-1:0] idx;
		data = {$urandom, $urandom};
		wa   = '0;
		if (miss_pending[tag]) begin
			wa = miss_addr_q[tag];
			if (mem_words.exists(wa))
				data = mem_words[wa];
			else
				mem_words[wa] = data;
		end
		step(bus_none, '0, '0, '0, tag, data);
		if (miss_pending[tag]) begin
			check_outputs(1'b1, tag, data, bus_none, '0, '0);
			idx = line_idx(wa);
			model_valid[idx] = 1'b1;
			model_tag[idx]   = line_tag(wa);
			model_data[idx]  = data;
			miss_pending[tag] = 1'b0;
		end else begin
			check_outputs(1'b0, '0, '0, bus_none, '0, '0);  // Stray tag
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic store_then_hit();
		logic [mem_tag_bits-1:0] t;
		store_word(64'h010d, 64'h0123_4567_89ab_cdef);
		load_word(64'h010c, 1'b0, t);  // Same word at another offset
	endtask

	task automatic miss_then_fill();
		logic [mem_tag_bits-1:0] t;
		load_word(64'h0240, 1'b0, t);
		return_fill(t);
		load_word(64'h0244, 1'b0, t);
	endtask

	task automatic out_of_order_fills();
		logic [mem_tag_bits-1:0] t1;
		logic [mem_tag_bits-1:0] t2;
		reset_dut();
		load_word(64'h0300, 1'b0, t1);
		load_word(64'h0318, 1'b0, t2);
		return_fill(t2);
		return_fill(t1);
		load_word(64'h0300, 1'b0, t1);
		load_word(64'h0318, 1'b0, t2);
	endtask

	task automatic conflict_eviction();
		logic [mem_tag_bits-1:0] t;
		store_word(64'h0410, 64'haaaa_5555_0000_0410);
		store_word(64'h0c10, 64'h5555_aaaa_0000_0c10);  // Same line with a new tag
		load_word(64'h0c10, 1'b0, t);
		load_word(64'h0410, 1'b0, t);
		return_fill(t);
		load_word(64'h0410, 1'b0, t);
	endtask

	task automatic refusal_and_stray();
		logic [mem_tag_bits-1:0] t;
		load_word(64'h0520, 1'b1, t);
		return_fill(next_tag);
		return_fill(4'd15);
		return_fill(4'd1);  // Retired earlier
		load_word(64'h0520, 1'b1, t);
	endtask

	task automatic reset_clears_cache();
		logic [mem_tag_bits-1:0] t;
		store_word(64'h0638, 64'hfeed_0000_0000_0638);
		load_word(64'h0638, 1'b0, t);
		reset_dut();
		load_word(64'h0638, 1'b0, t);
		return_fill(t);
	endtask

	initial begin
		void'($urandom(32'h14a2));
		reset = 1'b1;
		drive_idle();
		clear_model();
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		store_then_hit();
		miss_then_fill();
		out_of_order_fills();
		conflict_eviction();
		refusal_and_stray();
		reset_clears_cache();

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/dcache_pkg.sv
logic/dcache_mem.sv
logic/miss_table.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/dcache_properties.sv
dv/dcache_tb.sv

// ==== logic/dcache_ctrl.sv ====
/*
 * Data cache controller
 * Decodes processor and memory traffic, drives the array and the miss table
 */
`default_nettype none

module dcache_ctrl
	import dcache_pkg::*;
(
	// Processor request
	input  wire bus_command_e                proc_command,
	input  wire logic [addr_bits-1:0]        proc_addr,
	input  wire logic [data_bits-1:0]        proc_data,

	// Memory response
	input  wire logic [mem_tag_bits-1:0]     mem_response,
	input  wire logic [mem_tag_bits-1:0]     mem_tag,
	input  wire logic [data_bits-1:0]        mem_rd_data,

	// Memory request
	output bus_command_e                     mem_command,
	output logic      [addr_bits-1:0]        mem_addr,
	output logic      [data_bits-1:0]        mem_wr_data,

	// Processor response
	output logic      [data_bits-1:0]        proc_rd_data,
	output logic                             proc_valid,
	output logic      [mem_tag_bits-1:0]     proc_tag,

	// Cache array
	output logic      [dcache_idx_bits-1:0]  cache_rd_idx,
	output logic      [dcache_tag_bits-1:0]  cache_rd_tag,
	input  wire logic [data_bits-1:0]        cache_rd_data,
	input  wire logic                        cache_hit,
	output logic                             cache_wr_en,
	output logic      [dcache_idx_bits-1:0]  cache_wr_idx,
	output logic      [dcache_tag_bits-1:0]  cache_wr_tag,
	output logic      [data_bits-1:0]        cache_wr_data,

	// Miss table
	output logic                             mt_alloc,
	output logic      [mem_tag_bits-1:0]     mt_alloc_tag,
	output logic      [addr_bits-1:0]        mt_alloc_addr,
	output logic                             mt_retire,
	output logic      [mem_tag_bits-1:0]     mt_retire_tag,
	input  wire logic [addr_bits-1:0]        mt_retire_addr,
	input  wire logic                        mt_retire_valid
);

	logic [addr_bits-1:0] aligned_addr;
	logic                 fill;

	assign aligned_addr = {proc_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
	assign fill         = (mem_tag != '0);  // Memory returning data this cycle

	// Array lookup always follows the processor address
	assign cache_rd_idx = proc_addr[tag_lsb-1:idx_lsb];
	assign cache_rd_tag = proc_addr[tag_lsb+dcache_tag_bits-1:tag_lsb];

	assign mt_retire     = fill;
	assign mt_retire_tag = mem_tag;

	//////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////
	always_comb begin
		mem_command   = bus_none;
		mem_addr      = '0;
		mem_wr_data   = '0;
		proc_rd_data  = '0;
		proc_valid    = 1'b0;
		proc_tag      = '0;
		cache_wr_en   = 1'b0;
		cache_wr_idx  = '0;
		cache_wr_tag  = '0;
		cache_wr_data = '0;
		mt_alloc      = 1'b0;
		mt_alloc_tag  = '0;
		mt_alloc_addr = '0;

		if (fill) begin
			// Stray tags are dropped
			if (mt_retire_valid) begin
				cache_wr_en   = 1'b1;
				cache_wr_idx  = mt_retire_addr[tag_lsb-1:idx_lsb];
				cache_wr_tag  = mt_retire_addr[tag_lsb+dcache_tag_bits-1:tag_lsb];
				cache_wr_data = mem_rd_data;
				proc_rd_data  = mem_rd_data;
				proc_valid    = 1'b1;
				proc_tag      = mem_tag;
			end
		end else begin
			case (proc_command)
				bus_load: begin
					if (cache_hit) begin
						proc_rd_data = cache_rd_data;
						proc_valid   = 1'b1;
					end else if (mem_response != '0) begin  // Memory accepts the miss
						mem_command   = bus_load;
						mem_addr      = aligned_addr;
						proc_tag      = mem_response;
						mt_alloc      = 1'b1;
						mt_alloc_tag  = mem_response;
						mt_alloc_addr = aligned_addr;
					end
				end
				bus_store: begin
					// Write-through to array and memory
					cache_wr_en   = 1'b1;
					cache_wr_idx  = cache_rd_idx;
					cache_wr_tag  = cache_rd_tag;
					cache_wr_data = proc_data;
					mem_command   = bus_store;
					mem_addr      = aligned_addr;
					mem_wr_data   = proc_data;
				end
				default: begin
					// Idle cycle
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/dcache_mem.sv ====
/*
 * Direct-mapped data cache array
 * Data word, stored tag and valid bit per line; combinational read, clocked write
 */
`default_nettype none

module dcache_mem
	import dcache_pkg::*;
(
	input  wire logic                       clock,
	input  wire logic                       reset,

	// Read port
	input  wire logic [dcache_idx_bits-1:0] rd_idx,
	input  wire logic [dcache_tag_bits-1:0] rd_tag,
	output logic      [data_bits-1:0]       rd_data,
	output logic                            rd_hit,

	// Write port
	input  wire logic                       wr_en,
	input  wire logic [dcache_idx_bits-1:0] wr_idx,
	input  wire logic [dcache_tag_bits-1:0] wr_tag,
	input  wire logic [data_bits-1:0]       wr_data
);

	//////////////////////////////////////////////////
	// Line storage
	//////////////////////////////////////////////////
	logic [data_bits-1:0]       line_data [dcache_lines];
	logic [dcache_tag_bits-1:0] line_tag  [dcache_lines];
	logic [dcache_lines-1:0]    line_valid;

	// Valid bits are the only state that reset touches
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (wr_en) begin
			line_valid[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			line_data[wr_idx] <= wr_data;
			line_tag[wr_idx]  <= wr_tag;
		end
	end

	//////////////////////////////////////////////////
	// Read and hit compare
	//////////////////////////////////////////////////
	assign rd_data = line_data[rd_idx];
	assign rd_hit  = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);

endmodule

`default_nettype wire

// ==== logic/dcache_pkg.sv ====
/*
 * Data cache shared definitions
 * Address field widths, memory tag width and the bus command encoding
 */
`default_nettype none

package dcache_pkg;

	//////////////////////////////////////////////////
	// Address and data widths
	//////////////////////////////////////////////////
	localparam int addr_bits       = 64;
	localparam int data_bits       = 64;
	localparam int offset_bits     = 3;  // Byte offset within a word, ignored
	localparam int dcache_idx_bits = 5;  // 32 lines
	localparam int dcache_tag_bits = 8;  // Upper address bits are not compared

	// Memory transaction tags, 0 means none
	localparam int mem_tag_bits = 4;

	// Derived sizes and field positions
	localparam int dcache_lines = 1 << dcache_idx_bits;
	localparam int mt_entries   = 1 << mem_tag_bits;
	localparam int idx_lsb      = offset_bits;
	localparam int tag_lsb      = offset_bits + dcache_idx_bits;

	// Shared by processor and memory sides
	typedef enum logic [1:0] {
		bus_none  = 2'b00,
		bus_load  = 2'b01,
		bus_store = 2'b10
	} bus_command_e;

endpackage

`default_nettype wire

// ==== logic/dcache_top.sv ====
/*
 * Write-through direct-mapped data cache
 * Controller, line array and miss table between the load/store queue and memory
 */
`default_nettype none

module dcache_top
	import dcache_pkg::*;
(
	input  wire logic                    clock,
	input  wire logic                    reset,

	input  wire bus_command_e            proc_command,
	input  wire logic [addr_bits-1:0]    proc_addr,
	input  wire logic [data_bits-1:0]    proc_data,
	output logic      [data_bits-1:0]    proc_rd_data,
	output logic                         proc_valid,
	output logic      [mem_tag_bits-1:0] proc_tag,

	input  wire logic [mem_tag_bits-1:0] mem_response,
	input  wire logic [mem_tag_bits-1:0] mem_tag,
	input  wire logic [data_bits-1:0]    mem_rd_data,
	output bus_command_e                 mem_command,
	output logic      [addr_bits-1:0]    mem_addr,
	output logic      [data_bits-1:0]    mem_wr_data
);

	// Array side
	logic [dcache_idx_bits-1:0] cache_rd_idx;
	logic [dcache_tag_bits-1:0] cache_rd_tag;
	logic [data_bits-1:0]       cache_rd_data;
	logic                       cache_hit;
	logic                       cache_wr_en;
	logic [dcache_idx_bits-1:0] cache_wr_idx;
	logic [dcache_tag_bits-1:0] cache_wr_tag;
	logic [data_bits-1:0]       cache_wr_data;

	// Miss table side
	logic                    mt_alloc;
	logic [mem_tag_bits-1:0] mt_alloc_tag;
	logic [addr_bits-1:0]    mt_alloc_addr;
	logic                    mt_retire;
	logic [mem_tag_bits-1:0] mt_retire_tag;
	logic [addr_bits-1:0]    mt_retire_addr;
	logic                    mt_retire_valid;

	dcache_ctrl u_ctrl (.*);

	dcache_mem u_mem (
		.clock   (clock),
		.reset   (reset),
		.rd_idx  (cache_rd_idx),
		.rd_tag  (cache_rd_tag),
		.rd_data (cache_rd_data),
		.rd_hit  (cache_hit),
		.wr_en   (cache_wr_en),
		.wr_idx  (cache_wr_idx),
		.wr_tag  (cache_wr_tag),
		.wr_data (cache_wr_data)
	);

	miss_table u_miss_table (
		.clock        (clock),
		.reset        (reset),
		.alloc        (mt_alloc),
		.alloc_tag    (mt_alloc_tag),
		.alloc_addr   (mt_alloc_addr),
		.retire       (mt_retire),
		.retire_tag   (mt_retire_tag),
		.retire_addr  (mt_retire_addr),
		.retire_valid (mt_retire_valid)
	);

endmodule

`default_nettype wire

// ==== logic/miss_table.sv ====
/*
 * Outstanding load-miss table
 * One address per nonzero memory tag, looked up when memory returns the tag
 */
`default_nettype none

module miss_table
	import dcache_pkg::*;
(
	input  wire logic                    clock,
	input  wire logic                    reset,

	// New miss
	input  wire logic                    alloc,
	input  wire logic [mem_tag_bits-1:0] alloc_tag,
	input  wire logic [addr_bits-1:0]    alloc_addr,

	// Returning fill
	input  wire logic                    retire,
	input  wire logic [mem_tag_bits-1:0] retire_tag,
	output logic      [addr_bits-1:0]    retire_addr,
	output logic                         retire_valid
);

	logic [addr_bits-1:0]  miss_addr [mt_entries];
	logic [mt_entries-1:0] miss_valid;  // Bit 0 stays clear

	logic alloc_ok;

	// Tag 0 means no transaction
	assign alloc_ok = alloc && (alloc_tag != '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			miss_valid <= '0;
		end else begin
			if (retire)
				miss_valid[retire_tag] <= 1'b0;
			if (alloc_ok)
				miss_valid[alloc_tag] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (alloc_ok)
			miss_addr[alloc_tag] <= alloc_addr;
	end

	// Still readable in the retire cycle
	assign retire_addr  = miss_addr[retire_tag];
	assign retire_valid = miss_valid[retire_tag];

endmodule

`default_nettype wire
